// ==== design/bp_defs.svh ====
`ifndef BP_DEFS_SVH
`define BP_DEFS_SVH

// program counter and branch target width
`define BP_ADDR_W 32

// index bits, taken from pc[BP_IDX_W+1:2]
`define BP_IDX_W 6

`define BP_ENTRIES (1 << `BP_IDX_W)

// tag is everything above the index
`define BP_TAG_W (`BP_ADDR_W - `BP_IDX_W - 2)

`endif

// ==== design/bp_cfg_pkg.sv ====
package bp_cfg_pkg;

    localparam int CFG_DATA_W = 32;
    localparam int MISS_CNT_W = 16;

    typedef logic [CFG_DATA_W-1:0] cfg_data_t;

    // register map
    typedef enum logic [1:0] {
        CFG_CTRL     = 2'd0,
        CFG_STATUS   = 2'd1,
        CFG_MISS_CNT = 2'd2
    } cfg_addr_t;

    // bit positions in CTRL and STATUS
    localparam int CTRL_EN_BIT     = 0;
    localparam int CTRL_FLUSH_BIT  = 1;
    localparam int STATUS_BUSY_BIT = 0;

endpackage

// ==== design/bp_lookup_pkg.sv ====
`include "bp_defs.svh"

package bp_lookup_pkg;

    // one branch target buffer entry
    typedef struct packed {
        logic                  valid;
        logic [`BP_TAG_W-1:0]  tag;
        logic [`BP_ADDR_W-1:0] target;
    } btb_entry_t;

    // 2-bit saturating counter, msb set means predict taken
    typedef enum logic [1:0] {
        CTR_SNT = 2'b00, // strong not-taken
        CTR_WNT = 2'b01, // weak not-taken
        CTR_WT  = 2'b10, // weak taken
        CTR_ST  = 2'b11  // strong taken
    } ctr_t;

    // answer handed back to fetch
    typedef struct packed {
        logic                  taken;
        logic [`BP_ADDR_W-1:0] next_pc;
    } pred_t;

endpackage

// ==== design/bp_update_if.sv ====
`timescale 1ns/1ps

`include "bp_defs.svh"

// resolved branch outcome coming back from execute
interface bp_update_if;

    logic                  valid;
    logic [`BP_ADDR_W-1:0] pc;
    logic                  taken;
    logic [`BP_ADDR_W-1:0] target;
    logic                  mispredict; // fetch guessed wrong

    modport core (
        input valid,
        input pc,
        input taken,
        input target
    );

    modport monitor (
        input valid,
        input mispredict
    );

endinterface

// ==== design/bp_table.sv ====
`timescale 1ns/1ps

module bp_table #(
    parameter type entry_t = logic,
    parameter int  DEPTH   = 64
) (
    input  logic                     clk,
    input  logic                     rst_n_i,
    input  logic [$clog2(DEPTH)-1:0] rd_idx_i,
    output entry_t                   rd_data_o,
    input  logic                     we_i,
    input  logic [$clog2(DEPTH)-1:0] wr_idx_i,
    input  entry_t                   wr_data_i
);

    entry_t mem [DEPTH];

    // read port, same-index write returns old data
    always_ff @(posedge clk) begin
        rd_data_o <= mem[rd_idx_i];
    end

    // write port, blocked while reset is held
    always_ff @(posedge clk) begin
        if (rst_n_i && we_i) begin
            mem[wr_idx_i] <= wr_data_i;
        end
    end

endmodule

// ==== design/bp_core.sv ====
`timescale 1ns/1ps

`include "bp_defs.svh"

module bp_core (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  logic [`BP_ADDR_W-1:0] pc_i,
    input  logic                  pc_valid_i,
    input  logic                  enable_i,
    bp_update_if.core             upd,
    input  logic                  flush_req_i,
    output logic                  flush_ack_o,
    output logic                  pred_valid_o,
    output bp_lookup_pkg::pred_t  pred_o
);
    import bp_lookup_pkg::*;

    typedef enum logic [1:0] {
        FL_IDLE,
        FL_CLEAR,
        FL_ACK
    } fl_state_t;

    fl_state_t              fl_state_q;
    logic [`BP_IDX_W-1:0]   walk_idx_q;
    logic                   flush_active;
    logic                   flush_we;
    logic [`BP_IDX_W-1:0]   flush_idx;
    logic [`BP_ADDR_W-1:0]  pc_q;
    logic                   lk_valid_q;
    logic                   lk_en_q;
    btb_entry_t             btb_rd;
    ctr_t                   ctr_rd;
    logic                   hit_taken;
    logic [`BP_IDX_W-1:0]   upd_idx;
    logic [`BP_TAG_W-1:0]   upd_tag;
    logic                   upd_ok;
    logic                   upd_hit;
    logic [`BP_ENTRIES-1:0] sh_valid_q;
    logic [`BP_TAG_W-1:0]   sh_tag_q [`BP_ENTRIES];
    ctr_t                   sh_ctr_q [`BP_ENTRIES];
    ctr_t                   ctr_next;
    logic                   btb_we;
    logic                   ctr_we;
    logic [`BP_IDX_W-1:0]   wr_idx;
    btb_entry_t             btb_wr;
    ctr_t                   ctr_wr;

    function automatic ctr_t ctr_step(input ctr_t c, input logic taken);
        ctr_t n;
        case (c)
            CTR_SNT: n = taken ? CTR_WNT : CTR_SNT;
            CTR_WNT: n = taken ? CTR_WT  : CTR_SNT;
            CTR_WT:  n = taken ? CTR_ST  : CTR_WNT;
            default: n = taken ? CTR_ST  : CTR_WT;
        endcase
        return n;
    endfunction

    bp_table #(.entry_t(btb_entry_t), .DEPTH(`BP_ENTRIES)) i_btb_tbl (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .rd_idx_i  (pc_i[`BP_IDX_W+1:2]),
        .rd_data_o (btb_rd),
        .we_i      (btb_we),
        .wr_idx_i  (wr_idx),
        .wr_data_i (btb_wr)
    );

    bp_table #(.entry_t(ctr_t), .DEPTH(`BP_ENTRIES)) i_ctr_tbl (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .rd_idx_i  (pc_i[`BP_IDX_W+1:2]),
        .rd_data_o (ctr_rd),
        .we_i      (ctr_we),
        .wr_idx_i  (wr_idx),
        .wr_data_i (ctr_wr)
    );

    // index 0 is cleared at the edge that first sees the request
    assign flush_we     = (fl_state_q == FL_CLEAR) || (fl_state_q == FL_IDLE && flush_req_i);
    assign flush_idx    = (fl_state_q == FL_CLEAR) ? walk_idx_q : '0;
    assign flush_active = (fl_state_q != FL_IDLE) || flush_req_i;
    assign flush_ack_o  = (fl_state_q == FL_ACK);

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            fl_state_q <= FL_IDLE;
            walk_idx_q <= '0;
        end else begin
            case (fl_state_q)
                FL_IDLE: begin
                    if (flush_req_i) begin
                        fl_state_q <= FL_CLEAR;
                        walk_idx_q <= `BP_IDX_W'(1);
                    end
                end
                FL_CLEAR: begin
                    walk_idx_q <= walk_idx_q + 1'b1;
                    if (&walk_idx_q) begin
                        fl_state_q <= FL_ACK; // last index written
                    end
                end
                FL_ACK: begin
                    if (!flush_req_i) begin
                        fl_state_q <= FL_IDLE;
                    end
                end
                default: fl_state_q <= FL_IDLE;
            endcase
        end
    end

    // training works on the shadow copy, tables are fetch-only reads
    assign upd_idx  = upd.pc[`BP_IDX_W+1:2];
    assign upd_tag  = upd.pc[`BP_ADDR_W-1:`BP_IDX_W+2];
    assign upd_ok   = upd.valid && !flush_active;
    assign upd_hit  = sh_valid_q[upd_idx] && (sh_tag_q[upd_idx] == upd_tag);
    assign ctr_next = upd_hit ? ctr_step(sh_ctr_q[upd_idx], upd.taken) : CTR_WT;
    assign btb_we   = flush_we || (upd_ok && upd.taken); // allocate or retarget
    assign ctr_we   = flush_we || (upd_ok && (upd_hit || upd.taken));
    assign wr_idx   = flush_we ? flush_idx : upd_idx;

    always_comb begin
        if (flush_we) begin
            btb_wr = '0;
            ctr_wr = CTR_WNT;
        end else begin
            btb_wr = '{valid: 1'b1, tag: upd_tag, target: upd.target};
            ctr_wr = ctr_next;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            sh_valid_q <= '0;
        end else if (btb_we) begin
            sh_valid_q[wr_idx] <= btb_wr.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (btb_we) begin
            sh_tag_q[wr_idx] <= btb_wr.tag;
        end
        if (ctr_we) begin
            sh_ctr_q[wr_idx] <= ctr_wr;
        end
    end

    // second lookup stage, counter msb selects taken
    assign hit_taken = lk_en_q && btb_rd.valid && ctr_rd[1]
                       && (btb_rd.tag == pc_q[`BP_ADDR_W-1:`BP_IDX_W+2]);

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            lk_valid_q   <= 1'b0;
            lk_en_q      <= 1'b0;
            pred_valid_o <= 1'b0;
        end else begin
            lk_valid_q   <= pc_valid_i;
            lk_en_q      <= enable_i && !flush_active;
            pred_valid_o <= lk_valid_q;
        end
    end

    always_ff @(posedge clk) begin
        pc_q           <= pc_i;
        pred_o.taken   <= hit_taken;
        pred_o.next_pc <= hit_taken ? btb_rd.target : pc_q + `BP_ADDR_W'(4);
    end

endmodule

// ==== design/bp_cfg_regs.sv ====
`timescale 1ns/1ps

module bp_cfg_regs (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  logic                  cfg_we_i,
    input  bp_cfg_pkg::cfg_addr_t cfg_addr_i,
    input  bp_cfg_pkg::cfg_data_t cfg_wdata_i,
    output bp_cfg_pkg::cfg_data_t cfg_rdata_o,
    bp_update_if.monitor          upd,
    output logic                  flush_req_o,
    input  logic                  flush_ack_i,
    output logic                  enable_o
);
    import bp_cfg_pkg::*;

    logic                  enable_q;
    logic                  pend_q;
    logic                  req_q;
    logic [MISS_CNT_W-1:0] miss_cnt_q;
    logic                  ctrl_wr;
    logic                  busy;

    assign ctrl_wr     = cfg_we_i && (cfg_addr_i == CFG_CTRL);
    assign busy        = pend_q || req_q || flush_ack_i; // until ack falls
    assign flush_req_o = req_q;
    assign enable_o    = enable_q;

    // pending flush starts set so the tables get cleared after reset
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            enable_q <= 1'b0;
            pend_q   <= 1'b1;
            req_q    <= 1'b0;
        end else begin
            if (req_q && flush_ack_i) begin
                req_q <= 1'b0;                  // core done, release
            end else if (pend_q && !req_q && !flush_ack_i) begin
                req_q  <= 1'b1;                 // previous ack has dropped
                pend_q <= 1'b0;
            end
            if (ctrl_wr) begin
                enable_q <= cfg_wdata_i[CTRL_EN_BIT];
                if (cfg_wdata_i[CTRL_FLUSH_BIT]) begin
                    pend_q <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            miss_cnt_q <= '0;
        end else if (cfg_we_i && cfg_addr_i == CFG_MISS_CNT) begin
            miss_cnt_q <= '0;                   // any write clears
        end else if (upd.valid && upd.mispredict && !(&miss_cnt_q)) begin
            miss_cnt_q <= miss_cnt_q + 1'b1;
        end
    end

    always_comb begin
        cfg_rdata_o = '0;
        case (cfg_addr_i)
            CFG_CTRL: begin
                cfg_rdata_o[CTRL_EN_BIT]    = enable_q;
                cfg_rdata_o[CTRL_FLUSH_BIT] = pend_q;
            end
            CFG_STATUS:   cfg_rdata_o[STATUS_BUSY_BIT]  = busy;
            CFG_MISS_CNT: cfg_rdata_o[MISS_CNT_W-1:0]   = miss_cnt_q;
            default:      cfg_rdata_o = '0;
        endcase
    end

endmodule

// ==== design/branch_predictor_top.sv ====
`timescale 1ns/1ps

`include "bp_defs.svh"

module branch_predictor_top (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  logic [`BP_ADDR_W-1:0] pc_i,
    input  logic                  pc_valid_i,
    output logic                  pred_valid_o,
    output logic                  pred_taken_o,
    output logic [`BP_ADDR_W-1:0] pred_target_o,
    input  logic                  upd_valid_i,
    input  logic [`BP_ADDR_W-1:0] upd_pc_i,
    input  logic                  upd_taken_i,
    input  logic [`BP_ADDR_W-1:0] upd_target_i,
    input  logic                  upd_mispredict_i,
    input  logic                  cfg_we_i,
    input  bp_cfg_pkg::cfg_addr_t cfg_addr_i,
    input  bp_cfg_pkg::cfg_data_t cfg_wdata_i,
    output bp_cfg_pkg::cfg_data_t cfg_rdata_o
);
    import bp_lookup_pkg::*;

    logic  flush_req;
    logic  flush_ack;
    logic  enable;
    pred_t pred;

    bp_update_if upd_if ();

    assign upd_if.valid      = upd_valid_i;
    assign upd_if.pc         = upd_pc_i;
    assign upd_if.taken      = upd_taken_i;
    assign upd_if.target     = upd_target_i;
    assign upd_if.mispredict = upd_mispredict_i;

    assign pred_taken_o  = pred.taken;
    assign pred_target_o = pred.next_pc;

    bp_core i_core (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .pc_i         (pc_i),
        .pc_valid_i   (pc_valid_i),
        .enable_i     (enable),
        .upd          (upd_if.core),
        .flush_req_i  (flush_req),
        .flush_ack_o  (flush_ack),
        .pred_valid_o (pred_valid_o),
        .pred_o       (pred)
    );

    bp_cfg_regs i_cfg (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .cfg_we_i    (cfg_we_i),
        .cfg_addr_i  (cfg_addr_i),
        .cfg_wdata_i (cfg_wdata_i),
        .cfg_rdata_o (cfg_rdata_o),
        .upd         (upd_if.monitor),
        .flush_req_o (flush_req),
        .flush_ack_i (flush_ack),
        .enable_o    (enable)
    );

endmodule

// ==== dv/tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #50 clk_o = ~clk_o; // 100 ns period
    end

    initial begin
        rst_n_o = 1'b0;
        repeat (3) @(posedge clk_o);
        @(negedge clk_o);
        rst_n_o = 1'b1;
    end

endmodule

// ==== dv/bp_checker.sv ====
`timescale 1ns/1ps

`include "bp_defs.svh"

module bp_checker (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  logic                  pc_valid_i,
    input  logic                  exp_taken_i,
    input  logic [`BP_ADDR_W-1:0] exp_target_i,
    input  logic                  pred_valid_i,
    input  logic                  pred_taken_i,
    input  logic [`BP_ADDR_W-1:0] pred_target_i,
    output int                    err_cnt_o
);

    logic [`BP_ADDR_W:0] exp_q [$];
    int                  cyc_q [$];
    int                  cyc;

    initial begin
        err_cnt_o = 0;
        cyc       = 0;
    end

    // capture expectation at the edge that samples the lookup
    always @(posedge clk) begin
        cyc = cyc + 1;
        if (rst_n_i && pc_valid_i) begin
            exp_q.push_back({exp_taken_i, exp_target_i});
            cyc_q.push_back(cyc);
        end
    end

    always @(negedge clk) begin
        logic [`BP_ADDR_W:0] e;
        if (pred_valid_i) begin
            if (exp_q.size() == 0) begin
                $display("Unexpected prediction with no lookup outstanding at %0t", $time);
                err_cnt_o++;
            end else begin
                e = exp_q.pop_front();
                void'(cyc_q.pop_front());
                if (pred_taken_i !== e[`BP_ADDR_W]) begin
                    $display("Mismatch at %0t: taken got %b expected %b",
                             $time, pred_taken_i, e[`BP_ADDR_W]);
                    err_cnt_o++;
                end
                if (pred_target_i !== e[`BP_ADDR_W-1:0]) begin
                    $display("Mismatch at %0t: target got %h expected %h",
                             $time, pred_target_i, e[`BP_ADDR_W-1:0]);
                    err_cnt_o++;
                end
            end
        end else if (cyc_q.size() != 0 && cyc >= cyc_q[0] + 1) begin
            $display("Prediction valid missing for a lookup at %0t", $time);
            err_cnt_o++;
            void'(exp_q.pop_front());
            void'(cyc_q.pop_front());
        end
    end

    // register readback comparison, called from the testbench
    task automatic check_reg(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
            err_cnt_o++;
        end
    endtask

endmodule

// ==== dv/bp_assert.sv ====
`timescale 1ns/1ps

`include "bp_defs.svh"

module bp_assert (
    input logic                   clk,
    input logic                   rst_n_i,
    input logic                   flush_req_i,
    input logic                   flush_ack_i,
    input logic [`BP_ENTRIES-1:0] valid_bits_i
);

    ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n_i)
        $rose(flush_ack_i) |-> flush_req_i)
        else $error("flush ack rose without a request");

    req_holds: assert property (@(posedge clk) disable iff (!rst_n_i)
        (flush_req_i && !flush_ack_i) |=> flush_req_i)
        else $error("flush request dropped before ack");

    // no entry turns valid again while ack is high
    no_upd_write: assert property (@(posedge clk) disable iff (!rst_n_i)
        flush_ack_i |-> (valid_bits_i == '0))
        else $error("update wrote the tables during a flush");

endmodule

bind bp_core bp_assert i_assert (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .flush_req_i  (flush_req_i),
    .flush_ack_i  (flush_ack_o),
    .valid_bits_i (sh_valid_q)
);

// ==== dv/tb_branch_predictor.sv ====
`timescale 1ns/1ps

`include "bp_defs.svh"

module tb_branch_predictor;
    import bp_cfg_pkg::*;

    localparam int N_LK   = 48;
    localparam int N_RAND = 400;
    localparam int N_EN   = 64;
    localparam int WATCHDOG_CYCLES = 2 * N_LK + N_RAND + 2 * N_EN
                                     + 2 * (`BP_ENTRIES + 16) + 300;

    logic clk, rst_n;
    logic [`BP_ADDR_W-1:0] pc_i, upd_pc_i, upd_target_i, pred_target_o, exp_target;
    logic pc_valid_i, pred_valid_o, pred_taken_o, exp_taken;
    logic upd_valid_i, upd_taken_i, upd_mispredict_i, cfg_we_i;
    cfg_addr_t cfg_addr_i;
    cfg_data_t cfg_wdata_i, cfg_rdata_o;
    int chk_errors, tb_errors, miss_sent;
    logic [31:0] lcg_state;
    logic ref_en;
    logic ref_valid [`BP_ENTRIES];
    logic [`BP_TAG_W-1:0] ref_tag [`BP_ENTRIES];
    logic [`BP_ADDR_W-1:0] ref_tgt [`BP_ENTRIES];
    logic [1:0] ref_ctr [`BP_ENTRIES];

    tb_clk_gen i_clk_gen (.clk_o(clk), .rst_n_o(rst_n));

    branch_predictor_top i_dut (
        .clk(clk), .rst_n_i(rst_n), .pc_i(pc_i), .pc_valid_i(pc_valid_i),
        .pred_valid_o(pred_valid_o), .pred_taken_o(pred_taken_o),
        .pred_target_o(pred_target_o), .upd_valid_i(upd_valid_i), .upd_pc_i(upd_pc_i),
        .upd_taken_i(upd_taken_i), .upd_target_i(upd_target_i),
        .upd_mispredict_i(upd_mispredict_i), .cfg_we_i(cfg_we_i),
        .cfg_addr_i(cfg_addr_i), .cfg_wdata_i(cfg_wdata_i), .cfg_rdata_o(cfg_rdata_o)
    );

    bp_checker i_chk (
        .clk(clk), .rst_n_i(rst_n), .pc_valid_i(pc_valid_i), .exp_taken_i(exp_taken),
        .exp_target_i(exp_target), .pred_valid_i(pred_valid_o),
        .pred_taken_i(pred_taken_o), .pred_target_i(pred_target_o), .err_cnt_o(chk_errors)
    );

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // few tags over eight indices so hits and conflicts are common
    function automatic logic [`BP_ADDR_W-1:0] rand_pc();
        logic [31:0] r;
        r = lcg_next();
        return {`BP_TAG_W'(24'h00a000 + r[21:20]), 3'b101, r[18:16], 2'b00};
    endfunction

    function automatic logic [`BP_ADDR_W:0] predict_ref(input logic [`BP_ADDR_W-1:0] pc,
                                                        input logic en);
        int   idx;
        logic tk;
        idx = int'(pc[`BP_IDX_W+1:2]);
        tk  = en && ref_valid[idx] && ref_ctr[idx] >= 2
              && ref_tag[idx] == pc[`BP_ADDR_W-1:`BP_IDX_W+2];
        return {tk, tk ? ref_tgt[idx] : pc + 32'd4};
    endfunction

    task automatic ref_update(input logic [`BP_ADDR_W-1:0] pc, input logic tk,
                              input logic [`BP_ADDR_W-1:0] tgt);
        int idx;
        idx = int'(pc[`BP_IDX_W+1:2]);
        if (ref_valid[idx] && ref_tag[idx] == pc[`BP_ADDR_W-1:`BP_IDX_W+2]) begin
            if (tk) begin
                ref_tgt[idx] = tgt;
                ref_ctr[idx] = (ref_ctr[idx] == 2'd3) ? 2'd3 : ref_ctr[idx] + 2'd1;
            end else begin
                ref_ctr[idx] = (ref_ctr[idx] == 2'd0) ? 2'd0 : ref_ctr[idx] - 2'd1;
            end
        end else if (tk) begin // allocate as weak taken
            ref_valid[idx] = 1'b1;
            ref_tag[idx]   = pc[`BP_ADDR_W-1:`BP_IDX_W+2];
            ref_tgt[idx]   = tgt;
            ref_ctr[idx]   = 2'd2;
        end
    endtask

    task automatic ref_flush();
        for (int i = 0; i < `BP_ENTRIES; i++) begin
            ref_valid[i] = 1'b0;
            ref_ctr[i]   = 2'd1;
        end
    endtask

    // one cycle of fetch lookup and execute update
    task automatic step(input logic lk_v, input logic [31:0] lk_pc, input logic u_v,
                        input logic [31:0] u_pc, input logic u_tk, input logic [31:0] u_tgt,
                        input logic u_mis);
        logic [`BP_ADDR_W:0] pr;
        @(negedge clk);
        pr               = predict_ref(lk_pc, ref_en);
        exp_taken        = pr[`BP_ADDR_W];
        exp_target       = pr[`BP_ADDR_W-1:0];
        cfg_we_i         = 1'b0;
        pc_valid_i       = lk_v;
        pc_i             = lk_pc;
        upd_valid_i      = u_v;
        upd_pc_i         = u_pc;
        upd_taken_i      = u_tk;
        upd_target_i     = u_tgt;
        upd_mispredict_i = u_mis;
        if (u_v) begin
            ref_update(u_pc, u_tk, u_tgt);
            if (u_mis) miss_sent++;
        end
    endtask

    task automatic cfg_write(input cfg_addr_t a, input logic [31:0] d);
        @(negedge clk);
        pc_valid_i  = 1'b0;
        upd_valid_i = 1'b0;
        cfg_we_i    = 1'b1;
        cfg_addr_i  = a;
        cfg_wdata_i = d;
    endtask

    task automatic cfg_read(input cfg_addr_t a, output logic [31:0] v);
        @(negedge clk);
        pc_valid_i  = 1'b0;
        upd_valid_i = 1'b0;
        cfg_we_i    = 1'b0;
        cfg_addr_i  = a;
        #1 v = cfg_rdata_o; // combinational readback
    endtask

    task automatic wait_flush();
        logic [31:0] rd;
        int          n;
        rd = 32'd1;
        n  = 0;
        while (rd[STATUS_BUSY_BIT] && n < `BP_ENTRIES + 16) begin
            cfg_read(CFG_STATUS, rd);
            n++;
        end
        if (rd[STATUS_BUSY_BIT]) begin
            $display("Flush never completed, ack did not arrive at %0t", $time);
            tb_errors++;
        end
        ref_flush();
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired after %0d cycles, run did not finish", WATCHDOG_CYCLES);
        $display("errors: %0d checker, %0d testbench", chk_errors, tb_errors + 1);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        logic [31:0] r, tgt, rd, pc_a;
        lcg_state = 32'h928cc656;
        {pc_i, upd_pc_i, upd_target_i, cfg_wdata_i} = '0;
        {pc_valid_i, upd_valid_i, upd_taken_i, upd_mispredict_i, cfg_we_i} = '0;
        {exp_taken, exp_target} = '0;
        cfg_addr_i = CFG_CTRL;
        tb_errors  = 0;
        miss_sent  = 0;
        ref_en     = 1'b0;
        ref_flush();
        @(posedge rst_n);

        // reset flush, then everything falls through
        wait_flush();
        cfg_write(CFG_CTRL, 32'd1);
        ref_en = 1'b1;
        repeat (N_LK) step(1'b1, rand_pc(), 1'b0, '0, 1'b0, '0, 1'b0);

        // counter walk on one branch
        pc_a = 32'h00c0_0104;
        step(1'b0, '0, 1'b1, pc_a, 1'b1, 32'h0000_8000, 1'b1);
        step(1'b1, pc_a, 1'b1, pc_a, 1'b1, 32'h0000_8000, 1'b0);
        step(1'b1, pc_a, 1'b1, pc_a, 1'b0, '0, 1'b1);
        step(1'b1, pc_a, 1'b1, pc_a, 1'b0, '0, 1'b1);
        step(1'b1, pc_a, 1'b0, '0, 1'b0, '0, 1'b0);

        cfg_write(CFG_MISS_CNT, 32'd0);
        miss_sent = 0;
        for (int i = 0; i < N_RAND; i++) begin
            r   = lcg_next();
            tgt = lcg_next() & 32'hffff_fffc;
            // taken-biased first half, not-taken-biased second half
            step(r[21] | r[22], rand_pc(), r[23] | r[24], rand_pc(),
                 (i < N_RAND / 2) ? (r[26:25] != 2'b00) : (r[26:25] == 2'b00), tgt, r[27]);
        end
        cfg_read(CFG_MISS_CNT, rd);
        i_chk.check_reg("MISS_CNT", rd, 32'(miss_sent));
        cfg_write(CFG_MISS_CNT, 32'd0);
        cfg_read(CFG_MISS_CNT, rd);
        i_chk.check_reg("MISS_CNT after clear", rd, 32'd0);

        cfg_write(CFG_CTRL, 32'd0);
        ref_en = 1'b0;
        repeat (N_EN) step(1'b1, rand_pc(), 1'b0, '0, 1'b0, '0, 1'b0);
        cfg_write(CFG_CTRL, 32'd1);
        ref_en = 1'b1;
        repeat (N_EN) step(1'b1, rand_pc(), 1'b0, '0, 1'b0, '0, 1'b0);

        cfg_write(CFG_CTRL, 32'd3); // enable plus flush
        cfg_read(CFG_STATUS, rd);
        i_chk.check_reg("STATUS busy", rd, 32'd1);
        wait_flush();
        repeat (N_LK) step(1'b1, rand_pc(), 1'b0, '0, 1'b0, '0, 1'b0);
        repeat (4) step(1'b0, '0, 1'b0, '0, 1'b0, '0, 1'b0);

        $display("errors: %0d checker, %0d testbench", chk_errors, tb_errors);
        if (chk_errors + tb_errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== all.f ====
+incdir+design
design/bp_cfg_pkg.sv
design/bp_lookup_pkg.sv
design/bp_update_if.sv
design/bp_table.sv
design/bp_core.sv
design/bp_cfg_regs.sv
design/branch_predictor_top.sv
dv/tb_clk_gen.sv
dv/bp_checker.sv
dv/bp_assert.sv
dv/tb_branch_predictor.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_branch_predictor
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wall -Wno-fatal
LINTFLAGS ?= --lint-only --timing -Wall
PASS_MSG  := TEST RESULT: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)
